// File: list.f
source/io_pkg.sv
source/io_bus_stage.sv
source/gpio_port.sv
source/task_table.sv
source/io_readback.sv
source/io_hub.sv
test/io_hub_tb.sv

// File: Makefile
# Verilator build for the I/O hub testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= io_hub_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a non-zero exit status
run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: test/io_hub_tb.sv
`timescale 1ns/1ps
`default_nettype none

module io_hub_tb;

  localparam int RESET_CYCLES = 5;
  localparam int N_CYCLES     = 3000;                     // Random bus cycles
  localparam int MAX_CYCLES   = N_CYCLES + N_CYCLES / 3;  // Reset and drain fit easily
  localparam int N_USED       = 14;                       // Decoded address bits

  logic                 clk;
  logic                 resetq;
  logic                 io_rd;
  logic                 io_wr;
  io_pkg::data_t        mem_addr;
  io_pkg::data_t        dout;
  io_pkg::slot_t        io_slot;
  io_pkg::data_t        io_din;
  logic [3:0]           kill_slot_rq;
  io_pkg::port_t        pmod_in;
  io_pkg::port_t        pmod_out;
  io_pkg::port_t        pmod_oe;
  io_pkg::port_t        hdr1_in;
  io_pkg::port_t        hdr1_out;
  io_pkg::port_t        hdr1_oe;
  io_pkg::port_t        hdr2_in;
  io_pkg::port_t        hdr2_out;
  io_pkg::port_t        hdr2_oe;
  io_pkg::port_t        leds;
  logic [2:0]           misc_out;
  logic                 flash_miso;

  // Reference model state
  logic                 m_st_rd;
  logic                 m_st_wr;
  io_pkg::data_t        m_st_addr;
  io_pkg::data_t        m_st_data;
  io_pkg::slot_t        m_st_slot;
  io_pkg::port_t        m_pmod_out;
  io_pkg::port_t        m_pmod_dir;
  io_pkg::port_t        m_hdr1_out;
  io_pkg::port_t        m_hdr1_dir;
  io_pkg::port_t        m_hdr2_out;
  io_pkg::port_t        m_hdr2_dir;
  io_pkg::port_t        m_leds;
  logic [2:0]           m_misc;
  io_pkg::data_t        m_token [0:3];                    // Entry 0 unused
  logic [3:0]           m_kill;

  integer               seed;
  int                   rst_cnt;
  int                   n_rand;
  int                   n_tail;
  int                   cycle_cnt;
  logic                 checks_on;                        // DUT state is defined
  logic                 done;

  io_hub dut0 (
    .clk(clk), .resetq(resetq),
    .io_rd(io_rd), .io_wr(io_wr), .mem_addr(mem_addr), .dout(dout), .io_slot(io_slot),
    .io_din(io_din), .kill_slot_rq(kill_slot_rq),
    .pmod_in(pmod_in), .pmod_out(pmod_out), .pmod_oe(pmod_oe),
    .hdr1_in(hdr1_in), .hdr1_out(hdr1_out), .hdr1_oe(hdr1_oe),
    .hdr2_in(hdr2_in), .hdr2_out(hdr2_out), .hdr2_oe(hdr2_oe),
    .leds(leds), .misc_out(misc_out), .flash_miso(flash_miso)
  );

  always #5 clk = ~clk;                                   // 10 ns period

  function automatic int bit_of(input int idx);
    if (idx < 11)
      return idx;                                         // Ports, dirs, tasks
    return idx + 2;                                       // Skip bits 11 and 12
  endfunction

  // Driven pins show the register and the others the pad
  function automatic io_pkg::port_t pin_value(input io_pkg::port_t drv,
                                              input io_pkg::port_t dir,
                                              input io_pkg::port_t pad);
    io_pkg::port_t v;
    for (int b = 0; b < io_pkg::PORT_W; b++) begin
      v[b] = dir[b] ? drv[b] : pad[b];
    end
    return v;
  endfunction

  function automatic io_pkg::data_t fetch_value(input io_pkg::slot_t slot);
    if (slot == 2'd0)
      return '0;                                          // Slot 0 has no task
    return m_token[slot] & 16'hfffe;                      // Run-once flag hidden
  endfunction

  function automatic io_pkg::data_t expected_din();
    io_pkg::data_t d;
    d = '0;
    if (m_st_addr[io_pkg::ADDR_PMOD])
      d = d | io_pkg::data_t'(pin_value(m_pmod_out, m_pmod_dir, pmod_in));
    if (m_st_addr[io_pkg::ADDR_PMOD_DIR]) d = d | io_pkg::data_t'(m_pmod_dir);
    if (m_st_addr[io_pkg::ADDR_LEDS])     d = d | io_pkg::data_t'(m_leds);
    if (m_st_addr[io_pkg::ADDR_MISC_OUT]) d = d | io_pkg::data_t'(m_misc);
    if (m_st_addr[io_pkg::ADDR_HDR1])
      d = d | io_pkg::data_t'(pin_value(m_hdr1_out, m_hdr1_dir, hdr1_in));
    if (m_st_addr[io_pkg::ADDR_HDR1_DIR]) d = d | io_pkg::data_t'(m_hdr1_dir);
    if (m_st_addr[io_pkg::ADDR_HDR2])
      d = d | io_pkg::data_t'(pin_value(m_hdr2_out, m_hdr2_dir, hdr2_in));
    if (m_st_addr[io_pkg::ADDR_HDR2_DIR]) d = d | io_pkg::data_t'(m_hdr2_dir);
    for (int i = 1; i <= io_pkg::N_TASKS; i++) begin
      if (m_st_addr[io_pkg::ADDR_TASK1 + i - 1])
        d = d | m_token[i];                               // Raw token
    end
    if (m_st_addr[io_pkg::ADDR_MISC_IN])
      d[io_pkg::MISC_IN_MISO] = d[io_pkg::MISC_IN_MISO] | flash_miso;
    if (m_st_addr[io_pkg::ADDR_TASK_FETCH]) d = d | fetch_value(m_st_slot);
    if (m_st_addr[io_pkg::ADDR_SLOT_ID])    d = d | io_pkg::data_t'(m_st_slot);
    return d;
  endfunction

  // One clock edge of the model using the inputs the DUT samples
  task automatic advance_model();
    if (!resetq) begin
      m_st_rd = 1'b0;
      m_st_wr = 1'b0;
      m_st_addr = '0;
      m_st_data = '0;
      m_st_slot = '0;
      m_pmod_out = '0;
      m_pmod_dir = '0;
      m_hdr1_out = '0;
      m_hdr1_dir = '0;
      m_hdr2_out = '0;
      m_hdr2_dir = '0;
      m_leds = '0;
      m_misc = '0;
      for (int i = 0; i <= io_pkg::N_TASKS; i++) m_token[i] = '0;
      m_kill = '0;
    end else begin
      if (m_st_wr) begin
        if (m_st_addr[io_pkg::ADDR_PMOD])     m_pmod_out = m_st_data[7:0];
        if (m_st_addr[io_pkg::ADDR_PMOD_DIR]) m_pmod_dir = m_st_data[7:0];
        if (m_st_addr[io_pkg::ADDR_LEDS])     m_leds     = m_st_data[7:0];
        if (m_st_addr[io_pkg::ADDR_MISC_OUT]) m_misc     = m_st_data[2:0];
        if (m_st_addr[io_pkg::ADDR_HDR1])     m_hdr1_out = m_st_data[7:0];
        if (m_st_addr[io_pkg::ADDR_HDR1_DIR]) m_hdr1_dir = m_st_data[7:0];
        if (m_st_addr[io_pkg::ADDR_HDR2])     m_hdr2_out = m_st_data[7:0];
        if (m_st_addr[io_pkg::ADDR_HDR2_DIR]) m_hdr2_dir = m_st_data[7:0];
        for (int i = 1; i <= io_pkg::N_TASKS; i++) begin
          if (m_st_addr[io_pkg::ADDR_TASK1 + i - 1])
            m_token[i] = m_st_data;
        end
        m_kill = m_st_addr[io_pkg::ADDR_TASK_FETCH] ? m_st_data[3:0] : 4'h0;
      end else if (m_st_rd && m_st_addr[io_pkg::ADDR_TASK_FETCH] && m_st_slot != 2'd0) begin
        if (m_token[m_st_slot][0])
          m_token[m_st_slot] = '0;                        // Run-once task consumed
      end
      m_st_rd   = io_rd;
      m_st_wr   = io_wr;
      m_st_addr = (io_rd || io_wr) ? mem_addr : '0;
      m_st_data = dout;
      m_st_slot = io_slot;
    end
  endtask

  task automatic drive_random();
    logic [31:0]   r;
    io_pkg::data_t addr;
    r = $random(seed);
    addr = '0;
    addr[bit_of(int'(r[15:8]) % N_USED)] = 1'b1;
    if (r[20:18] == 3'd0)
      addr[bit_of(int'(r[28:24]) % N_USED)] = 1'b1;       // Occasional double hit
    io_rd    <= (r[1:0] == 2'd1) || (r[1:0] == 2'd3);
    io_wr    <= (r[1:0] == 2'd2) || (r[1:0] == 2'd3 && r[3:2] == 2'd0);  // Rare dual strobe
    mem_addr <= addr;
    io_slot  <= r[31:30];
    dout     <= 16'($random(seed));
    r = $random(seed);
    pmod_in    <= r[7:0];
    hdr1_in    <= r[15:8];
    hdr2_in    <= r[23:16];
    flash_miso <= r[24];
  endtask

  task automatic compare_word(input string name, input io_pkg::data_t got,
                              input io_pkg::data_t exp);
    assert (got === exp) else begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      $display("Checks failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic expect_reset_state();
    compare_word("io_din", io_din, '0);
    compare_word("kill_slot_rq", io_pkg::data_t'(kill_slot_rq), '0);
    compare_word("pmod_oe", io_pkg::data_t'(pmod_oe), '0);
    compare_word("hdr1_oe", io_pkg::data_t'(hdr1_oe), '0);
    compare_word("hdr2_oe", io_pkg::data_t'(hdr2_oe), '0);
    compare_word("leds", io_pkg::data_t'(leds), '0);
    compare_word("misc_out", io_pkg::data_t'(misc_out), '0);
  endtask

  always @(posedge clk) begin
    advance_model();
    checks_on = 1'b1;
    if (rst_cnt < RESET_CYCLES) begin
      rst_cnt++;
      if (rst_cnt == RESET_CYCLES)
        resetq <= 1'b1;                                   // Released after 5 edges
    end else if (n_rand < N_CYCLES) begin
      drive_random();
      n_rand++;
    end else begin
      io_rd <= 1'b0;                                      // Drain the stage
      io_wr <= 1'b0;
      n_tail++;
      if (n_tail == 2)
        done = 1'b1;
    end
  end

  // Outputs settle mid-cycle
  always @(negedge clk) begin
    if (checks_on) begin
      if (!resetq)
        expect_reset_state();
      compare_word("io_din", io_din, expected_din());
      compare_word("kill_slot_rq", io_pkg::data_t'(kill_slot_rq), io_pkg::data_t'(m_kill));
      compare_word("pmod_out", io_pkg::data_t'(pmod_out), io_pkg::data_t'(m_pmod_out));
      compare_word("pmod_oe", io_pkg::data_t'(pmod_oe), io_pkg::data_t'(m_pmod_dir));
      compare_word("hdr1_out", io_pkg::data_t'(hdr1_out), io_pkg::data_t'(m_hdr1_out));
      compare_word("hdr1_oe", io_pkg::data_t'(hdr1_oe), io_pkg::data_t'(m_hdr1_dir));
      compare_word("hdr2_out", io_pkg::data_t'(hdr2_out), io_pkg::data_t'(m_hdr2_out));
      compare_word("hdr2_oe", io_pkg::data_t'(hdr2_oe), io_pkg::data_t'(m_hdr2_dir));
      compare_word("leds", io_pkg::data_t'(leds), io_pkg::data_t'(m_leds));
      compare_word("misc_out", io_pkg::data_t'(misc_out), io_pkg::data_t'(m_misc));
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Checks failed");
      $fatal(1, "Timeout, run still going after %0d cycles", MAX_CYCLES);
    end
  end

  initial begin
    seed       = 32'hbf58;
    clk        = 1'b0;
    resetq     = 1'b0;
    io_rd      = 1'b0;
    io_wr      = 1'b0;
    mem_addr   = '0;
    dout       = '0;
    io_slot    = '0;
    pmod_in    = '0;
    hdr1_in    = '0;
    hdr2_in    = '0;
    flash_miso = 1'b0;
    rst_cnt    = 0;
    n_rand     = 0;
    n_tail     = 0;
    cycle_cnt  = 0;
    checks_on  = 1'b0;
    done       = 1'b0;
    wait (done == 1'b1);
    @(posedge clk);                                       // Last negedge check done
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: source/io_hub.sv
`timescale 1ns/1ps
`default_nettype none

module io_hub (
  input  wire                            clk,
  input  wire                            resetq,
  // Processor side
  input  wire                            io_rd,
  input  wire                            io_wr,
  input  wire io_pkg::data_t             mem_addr,
  input  wire io_pkg::data_t             dout,
  input  wire io_pkg::slot_t             io_slot,
  output io_pkg::data_t                  io_din,
  output logic [io_pkg::KILL_W-1:0]      kill_slot_rq,
  // PMOD
  input  wire io_pkg::port_t             pmod_in,
  output io_pkg::port_t                  pmod_out,
  output io_pkg::port_t                  pmod_oe,
  // Header 1
  input  wire io_pkg::port_t             hdr1_in,
  output io_pkg::port_t                  hdr1_out,
  output io_pkg::port_t                  hdr1_oe,
  // Header 2
  input  wire io_pkg::port_t             hdr2_in,
  output io_pkg::port_t                  hdr2_out,
  output io_pkg::port_t                  hdr2_oe,
  // Output-only pins
  output io_pkg::port_t                  leds,
  output logic [io_pkg::MISC_OUT_W-1:0]  misc_out,     // {SCK, MOSI, CS}
  input  wire                            flash_miso
);

  // Staged bus
  logic          st_rd;
  logic          st_wr;
  io_pkg::data_t st_addr;
  io_pkg::data_t st_data;
  io_pkg::slot_t st_slot;

  // Read-back sources
  io_pkg::port_t                 pmod_rd;
  io_pkg::port_t                 pmod_dir;
  io_pkg::port_t                 hdr1_rd;
  io_pkg::port_t                 hdr1_dir;
  io_pkg::port_t                 hdr2_rd;
  io_pkg::port_t                 hdr2_dir;
  io_pkg::port_t                 leds_rd;
  logic [io_pkg::MISC_OUT_W-1:0] misc_out_rd;
  io_pkg::data_t                 task_word1;
  io_pkg::data_t                 task_word2;
  io_pkg::data_t                 task_word3;
  io_pkg::data_t                 task_fetch;

  io_bus_stage u_stage (
    .clk(clk), .resetq(resetq),
    .io_rd(io_rd), .io_wr(io_wr), .mem_addr(mem_addr), .dout(dout), .io_slot(io_slot),
    .st_addr(st_addr), .st_data(st_data), .st_slot(st_slot),
    .st_rd(st_rd), .st_wr(st_wr)
  );

  gpio_port #(
    .WIDTH(io_pkg::PORT_W), .HAS_DIR(1),
    .DATA_BIT(io_pkg::ADDR_PMOD), .DIR_BIT(io_pkg::ADDR_PMOD_DIR)
  ) u_pmod (
    .clk(clk), .resetq(resetq),
    .st_wr(st_wr), .st_addr(st_addr), .st_data(st_data),
    .pad_in(pmod_in), .pad_out(pmod_out), .pad_oe(pmod_oe),
    .rd_val(pmod_rd), .dir_val(pmod_dir)
  );

  gpio_port #(
    .WIDTH(io_pkg::PORT_W), .HAS_DIR(1),
    .DATA_BIT(io_pkg::ADDR_HDR1), .DIR_BIT(io_pkg::ADDR_HDR1_DIR)
  ) u_hdr1 (
    .clk(clk), .resetq(resetq),
    .st_wr(st_wr), .st_addr(st_addr), .st_data(st_data),
    .pad_in(hdr1_in), .pad_out(hdr1_out), .pad_oe(hdr1_oe),
    .rd_val(hdr1_rd), .dir_val(hdr1_dir)
  );

  gpio_port #(
    .WIDTH(io_pkg::PORT_W), .HAS_DIR(1),
    .DATA_BIT(io_pkg::ADDR_HDR2), .DIR_BIT(io_pkg::ADDR_HDR2_DIR)
  ) u_hdr2 (
    .clk(clk), .resetq(resetq),
    .st_wr(st_wr), .st_addr(st_addr), .st_data(st_data),
    .pad_in(hdr2_in), .pad_out(hdr2_out), .pad_oe(hdr2_oe),
    .rd_val(hdr2_rd), .dir_val(hdr2_dir)
  );

  // LEDs always drive, so they read back their own register
  gpio_port #(
    .WIDTH(io_pkg::PORT_W), .HAS_DIR(0),
    .DATA_BIT(io_pkg::ADDR_LEDS), .DIR_BIT(io_pkg::ADDR_LEDS)
  ) u_leds (
    .clk(clk), .resetq(resetq),
    .st_wr(st_wr), .st_addr(st_addr), .st_data(st_data),
    .pad_in('0), .pad_out(leds), .pad_oe(),
    .rd_val(leds_rd), .dir_val()
  );

  gpio_port #(
    .WIDTH(io_pkg::MISC_OUT_W), .HAS_DIR(0),
    .DATA_BIT(io_pkg::ADDR_MISC_OUT), .DIR_BIT(io_pkg::ADDR_MISC_OUT)
  ) u_misc (
    .clk(clk), .resetq(resetq),
    .st_wr(st_wr), .st_addr(st_addr), .st_data(st_data),
    .pad_in('0), .pad_out(misc_out), .pad_oe(),
    .rd_val(misc_out_rd), .dir_val()
  );

  task_table u_tasks (
    .clk(clk), .resetq(resetq),
    .st_rd(st_rd), .st_wr(st_wr), .st_addr(st_addr), .st_data(st_data), .st_slot(st_slot),
    .task_word1(task_word1), .task_word2(task_word2), .task_word3(task_word3),
    .task_fetch(task_fetch), .kill_slot_rq(kill_slot_rq)
  );

  io_readback u_readback (
    .st_addr(st_addr), .st_slot(st_slot),
    .pmod_rd(pmod_rd), .pmod_dir(pmod_dir),
    .leds_rd(leds_rd), .misc_out_rd(misc_out_rd),
    .hdr1_rd(hdr1_rd), .hdr1_dir(hdr1_dir),
    .hdr2_rd(hdr2_rd), .hdr2_dir(hdr2_dir),
    .flash_miso(flash_miso),
    .task_word1(task_word1), .task_word2(task_word2), .task_word3(task_word3),
    .task_fetch(task_fetch),
    .io_din(io_din)
  );

endmodule

`default_nettype wire

// File: source/io_readback.sv
`timescale 1ns/1ps
`default_nettype none

// Read data back to the processor. Each address bit gates one source,
// and all gated sources are ORed, so a multi-hot read merges them.
module io_readback (
  input  wire io_pkg::data_t                  st_addr,
  input  wire io_pkg::slot_t                  st_slot,
  input  wire io_pkg::port_t                  pmod_rd,
  input  wire io_pkg::port_t                  pmod_dir,
  input  wire io_pkg::port_t                  leds_rd,
  input  wire [io_pkg::MISC_OUT_W-1:0]        misc_out_rd,
  input  wire io_pkg::port_t                  hdr1_rd,
  input  wire io_pkg::port_t                  hdr1_dir,
  input  wire io_pkg::port_t                  hdr2_rd,
  input  wire io_pkg::port_t                  hdr2_dir,
  input  wire                                 flash_miso,
  input  wire io_pkg::data_t                  task_word1,
  input  wire io_pkg::data_t                  task_word2,
  input  wire io_pkg::data_t                  task_word3,
  input  wire io_pkg::data_t                  task_fetch,
  output io_pkg::data_t                       io_din
);

  io_pkg::data_t misc_in;                 // Misc input word

  // Only MISO is left in the misc input word
  assign misc_in = io_pkg::data_t'(flash_miso) << io_pkg::MISC_IN_MISO;

  always_comb begin
    io_din = '0;                          // Idle cycle reads zero
    if (st_addr[io_pkg::ADDR_PMOD])       io_din |= io_pkg::data_t'(pmod_rd);
    if (st_addr[io_pkg::ADDR_PMOD_DIR])   io_din |= io_pkg::data_t'(pmod_dir);
    if (st_addr[io_pkg::ADDR_LEDS])       io_din |= io_pkg::data_t'(leds_rd);
    if (st_addr[io_pkg::ADDR_MISC_OUT])   io_din |= io_pkg::data_t'(misc_out_rd);
    if (st_addr[io_pkg::ADDR_HDR1])       io_din |= io_pkg::data_t'(hdr1_rd);
    if (st_addr[io_pkg::ADDR_HDR1_DIR])   io_din |= io_pkg::data_t'(hdr1_dir);
    if (st_addr[io_pkg::ADDR_HDR2])       io_din |= io_pkg::data_t'(hdr2_rd);
    if (st_addr[io_pkg::ADDR_HDR2_DIR])   io_din |= io_pkg::data_t'(hdr2_dir);
    // Raw tokens, run-once flag included
    if (st_addr[io_pkg::ADDR_TASK1])      io_din |= task_word1;
    if (st_addr[io_pkg::ADDR_TASK2])      io_din |= task_word2;
    if (st_addr[io_pkg::ADDR_TASK3])      io_din |= task_word3;
    if (st_addr[io_pkg::ADDR_MISC_IN])    io_din |= misc_in;
    if (st_addr[io_pkg::ADDR_TASK_FETCH]) io_din |= task_fetch;
    // Slot that issued this read
    if (st_addr[io_pkg::ADDR_SLOT_ID])    io_din |= io_pkg::data_t'(st_slot);
  end

endmodule

`default_nettype wire

// File: source/task_table.sv
`timescale 1ns/1ps
`default_nettype none

// Execution tokens for slots 1 to 3. Slot 0 has no entry and always
// fetches zero. A token with bit 0 set is a run-once task and is wiped
// by the first fetch from its own slot.
module task_table (
  input  wire                       clk,
  input  wire                       resetq,
  input  wire                       st_rd,
  input  wire                       st_wr,
  input  wire io_pkg::data_t        st_addr,
  input  wire io_pkg::data_t        st_data,
  input  wire io_pkg::slot_t        st_slot,
  output io_pkg::data_t             task_word1,   // Raw token, slot 1
  output io_pkg::data_t             task_word2,   // Raw token, slot 2
  output io_pkg::data_t             task_word3,   // Raw token, slot 3
  output io_pkg::data_t             task_fetch,   // Token of the reading slot
  output logic [io_pkg::KILL_W-1:0] kill_slot_rq  // Bit n kills slot n
);

  io_pkg::data_t token_q [io_pkg::N_TASKS];       // Index 0 is slot 1
  logic          fetch_rd;                        // Fetch read staged

  assign fetch_rd = st_rd && st_addr[io_pkg::ADDR_TASK_FETCH];

  always_ff @(posedge clk) begin
    if (!resetq) begin
      for (int i = 0; i < io_pkg::N_TASKS; i++) begin
        token_q[i] <= '0;                         // Stops every task
      end
      kill_slot_rq <= '0;
    end else if (st_wr) begin
      // Any slot may schedule any other
      for (int i = 0; i < io_pkg::N_TASKS; i++) begin
        if (st_addr[io_pkg::ADDR_TASK1 + i])
          token_q[i] <= st_data;
      end
      // Pulse-like request, cleared by the next unrelated write
      kill_slot_rq <= st_addr[io_pkg::ADDR_TASK_FETCH] ?
                      st_data[io_pkg::KILL_W-1:0] : '0;
    end else if (fetch_rd) begin
      // Write wins over run-once clear
      for (int i = 0; i < io_pkg::N_TASKS; i++) begin
        if (st_slot == io_pkg::SLOT_W'(i + 1) && token_q[i][0])
          token_q[i] <= '0;
      end
    end
  end

  assign task_word1 = token_q[0];
  assign task_word2 = token_q[1];
  assign task_word3 = token_q[2];

  // Valid tokens are even, bit 0 is only the run-once flag
  always_comb begin
    case (st_slot)
      2'd1:    task_fetch = {token_q[0][io_pkg::DATA_W-1:1], 1'b0};
      2'd2:    task_fetch = {token_q[1][io_pkg::DATA_W-1:1], 1'b0};
      2'd3:    task_fetch = {token_q[2][io_pkg::DATA_W-1:1], 1'b0};
      default: task_fetch = '0;                   // Slot 0 runs from zero
    endcase
  end

endmodule

`default_nettype wire

// File: source/gpio_port.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_port #(
  parameter int WIDTH    = 8,             // Port width
  parameter int HAS_DIR  = 1,             // 0 for output-only ports
  parameter int DATA_BIT = 0,             // Address bit of output register
  parameter int DIR_BIT  = 1              // Address bit of direction register
) (
  input  wire                 clk,
  input  wire                 resetq,
  input  wire                 st_wr,
  input  wire io_pkg::data_t  st_addr,
  input  wire io_pkg::data_t  st_data,
  input  wire [WIDTH-1:0]     pad_in,     // Pad sampled value
  output logic [WIDTH-1:0]    pad_out,    // Pad drive value
  output logic [WIDTH-1:0]    pad_oe,     // Pad drive enable
  output logic [WIDTH-1:0]    rd_val,     // Resolved pin value
  output logic [WIDTH-1:0]    dir_val     // Direction for read-back
);

  // Output register
  always_ff @(posedge clk) begin
    if (!resetq)
      pad_out <= '0;
    else if (st_wr && st_addr[DATA_BIT])
      pad_out <= st_data[WIDTH-1:0];      // Low bits only
  end

  generate
    if (HAS_DIR != 0) begin : g_dir
      logic [WIDTH-1:0] dir_q;            // 1 drives, 0 listens

      always_ff @(posedge clk) begin
        if (!resetq)
          dir_q <= '0;                    // All pins start as inputs
        else if (st_wr && st_addr[DIR_BIT])
          dir_q <= st_data[WIDTH-1:0];
      end

      assign pad_oe  = dir_q;
      assign dir_val = dir_q;
    end else begin : g_no_dir
      assign pad_oe  = '1;                // Always driven
      assign dir_val = '0;                // No direction register
    end
  endgenerate

  // Driven pins read back their own value, inputs read the pad
  assign rd_val = (pad_oe & pad_out) | (~pad_oe & pad_in);

endmodule

`default_nettype wire

// File: source/io_bus_stage.sv
`timescale 1ns/1ps
`default_nettype none

// The processor presents address and data for a single cycle only, so
// everything is captured here and the rest of the hub works off the
// registered copy one cycle later.
module io_bus_stage (
  input  wire                 clk,
  input  wire                 resetq,
  input  wire                 io_rd,      // Read strobe, one cycle
  input  wire                 io_wr,      // Write strobe, one cycle
  input  wire io_pkg::data_t  mem_addr,   // One-hot I/O address
  input  wire io_pkg::data_t  dout,       // Write data
  input  wire io_pkg::slot_t  io_slot,    // Slot issuing the access
  output io_pkg::data_t       st_addr,    // Zero when idle
  output io_pkg::data_t       st_data,
  output io_pkg::slot_t       st_slot,
  output logic                st_rd,
  output logic                st_wr
);

  logic access;                           // Any strobe this cycle

  assign access = io_rd | io_wr;

  always_ff @(posedge clk) begin
    if (!resetq) begin
      st_rd   <= 1'b0;
      st_wr   <= 1'b0;
      st_addr <= '0;
      st_data <= '0;
      st_slot <= '0;
    end else begin
      st_rd   <= io_rd;
      st_wr   <= io_wr;
      st_data <= dout;                    // Harmless when idle
      st_slot <= io_slot;                 // Needed for fetch and slot ID
      // Stale address bits must not select anything on an idle cycle
      st_addr <= access ? mem_addr : '0;
    end
  end

endmodule

`default_nettype wire

// File: source/io_pkg.sv
`default_nettype none

package io_pkg;

  // Word and port widths
  localparam int DATA_W     = 16;       // Processor data word
  localparam int PORT_W     = 8;        // GPIO and LED ports
  localparam int MISC_OUT_W = 3;        // Flash CS, MOSI, SCK
  localparam int SLOT_W     = 2;        // Four barrel slots
  localparam int N_TASKS    = 3;        // Tokens for slots 1..3 only
  localparam int KILL_W     = 4;        // One kill bit per slot

  // One-hot I/O address bits
  localparam int ADDR_PMOD       = 0;   // PMOD pins
  localparam int ADDR_PMOD_DIR   = 1;   // PMOD direction, 1 drives
  localparam int ADDR_LEDS       = 2;   // LED bank
  localparam int ADDR_MISC_OUT   = 3;   // Flash control pins
  localparam int ADDR_HDR1       = 4;   // Header 1 pins
  localparam int ADDR_HDR1_DIR   = 5;   // Header 1 direction
  localparam int ADDR_HDR2       = 6;   // Header 2 pins
  localparam int ADDR_HDR2_DIR   = 7;   // Header 2 direction
  localparam int ADDR_TASK1      = 8;   // Slot 1 token
  localparam int ADDR_TASK2      = 9;   // Slot 2 token
  localparam int ADDR_TASK3      = 10;  // Slot 3 token
  // Bits 11 and 12 are free
  localparam int ADDR_MISC_IN    = 13;  // Misc input word, read only
  localparam int ADDR_TASK_FETCH = 14;  // Per-slot fetch, write kills
  localparam int ADDR_SLOT_ID    = 15;  // Slot of the reader

  // Misc input word layout
  localparam int MISC_IN_MISO = 2;      // Flash MISO

  // Common word types
  typedef logic [DATA_W-1:0] data_t;    // Data or address word
  typedef logic [SLOT_W-1:0] slot_t;    // Slot number
  typedef logic [PORT_W-1:0] port_t;    // One GPIO port

endpackage

`default_nettype wire
